/* hw/simd_pkg.sv */
package simd_pkg;

    localparam int DATA_SIZE = 64;      // Lane width
    localparam int VLEN_DEF  = 128;     // Default vector length, multiple of DATA_SIZE
    localparam int NUM_VREGS = 8;

    typedef logic [DATA_SIZE-1:0]         bus64_t;
    typedef logic [$clog2(NUM_VREGS)-1:0] vreg_idx_t;
    typedef logic [4:0]                   imm_t;     // Sign-extended where used

    // Selected element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    // Vector operations, the last three give a scalar result
    typedef enum logic [3:0] {
        VADD    = 4'd0,
        VSUB    = 4'd1,
        VAND    = 4'd2,
        VOR     = 4'd3,
        VXOR    = 4'd4,
        VSEQ    = 4'd5,     // All ones on equal elements
        VMV_X_S = 4'd6,     // Element 0 to scalar
        VEXT    = 4'd7,     // Element selected by rs1
        VCNT    = 4'd8      // Run of equal elements from element 0
    } vop_t;

    // Source of the first operand
    typedef enum logic [1:0] {
        OP_VV = 2'd0,
        OP_VX = 2'd1,
        OP_VI = 2'd2
    } opmode_t;

endpackage

/* hw/vrf_wr_if.sv */
`timescale 1ns/10ps

// One requester's path to the shared write port of the register file
interface vrf_wr_if import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) ();

    logic            req;
    vreg_idx_t       idx;
    logic [VLEN-1:0] data;
    logic            gnt;   // Write happens at the edge ending this cycle

    modport requester (output req, output idx, output data, input gnt);
    modport arbiter   (input req, input idx, input data, output gnt);

endinterface

/* hw/simd_lane.sv */
`timescale 1ns/10ps

module simd_lane import simd_pkg::*; (
    input  vop_t   op_i,
    input  sew_t   sew_i,
    input  bus64_t a_i,         // vs1 side, or replicated scalar
    input  bus64_t b_i,         // vs2 side
    output bus64_t y_o
);

    // Operands arrive zero-extended, so only the low bits of add and sub are kept
    function automatic bus64_t elem_op(input vop_t op, input bus64_t a, input bus64_t b);
        bus64_t r;
        case (op)
            VADD:    r = b + a;
            VSUB:    r = b - a;     // vs2 minus vs1
            VAND:    r = b & a;
            VOR:     r = b | a;
            VXOR:    r = b ^ a;
            VSEQ:    r = (a == b) ? '1 : '0;
            default: r = '0;
        endcase
        return r;
    endfunction

    always_comb begin
        bus64_t r;
        y_o = '0;
        case (sew_i)
            SEW_8: begin
                for (int e = 0; e < 8; e++) begin
                    r = elem_op(op_i, bus64_t'(a_i[e*8 +: 8]), bus64_t'(b_i[e*8 +: 8]));
                    y_o[e*8 +: 8] = r[7:0];
                end
            end
            SEW_16: begin
                for (int e = 0; e < 4; e++) begin
                    r = elem_op(op_i, bus64_t'(a_i[e*16 +: 16]), bus64_t'(b_i[e*16 +: 16]));
                    y_o[e*16 +: 16] = r[15:0];
                end
            end
            SEW_32: begin
                for (int e = 0; e < 2; e++) begin
                    r = elem_op(op_i, bus64_t'(a_i[e*32 +: 32]), bus64_t'(b_i[e*32 +: 32]));
                    y_o[e*32 +: 32] = r[31:0];
                end
            end
            default: y_o = elem_op(op_i, a_i, b_i);
        endcase
    end

endmodule

/* hw/simd_alu.sv */
`timescale 1ns/10ps

module simd_alu import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) (
    input  vop_t              op_i,
    input  opmode_t           mode_i,
    input  sew_t              sew_i,
    input  logic              masked_i,
    input  bus64_t            rs1_i,
    input  imm_t              imm_i,
    input  logic [VLEN-1:0]   vs1_i,
    input  logic [VLEN-1:0]   vs2_i,
    input  logic [VLEN-1:0]   old_vd_i,
    input  logic [VLEN/8-1:0] vmask_i,    // One bit per element, from v0
    output logic [VLEN-1:0]   vresult_o,
    output bus64_t            sresult_o
);

    localparam int NUM_LANES = VLEN / DATA_SIZE;
    localparam int MAX_ELEMS = VLEN / 8;
    localparam int IDX_W     = $clog2(MAX_ELEMS);

    bus64_t          scalar_src;
    logic [VLEN-1:0] rs1_rep;
    logic [VLEN-1:0] op_a;
    logic [VLEN-1:0] raw;           // Lane results before the mask
    vop_t            lane_op;
    logic [2:0]      sh;            // log2 of the element width
    bus64_t          emask;         // Low element-width bits set
    logic [VLEN-1:0] ext_shift;
    bus64_t          ext_val;
    bus64_t          cnt;

    assign scalar_src = (mode_i == OP_VI) ? {{(DATA_SIZE-5){imm_i[4]}}, imm_i} : rs1_i;

    // Element width decode
    always_comb begin
        case (sew_i)
            SEW_8: begin
                sh    = 3'd3;
                emask = 64'h0000_0000_0000_00ff;
            end
            SEW_16: begin
                sh    = 3'd4;
                emask = 64'h0000_0000_0000_ffff;
            end
            SEW_32: begin
                sh    = 3'd5;
                emask = 64'h0000_0000_ffff_ffff;
            end
            default: begin
                sh    = 3'd6;
                emask = '1;
            end
        endcase
    end

    // Scalar or immediate copied into every element
    always_comb begin
        case (sew_i)
            SEW_8:   rs1_rep = {(VLEN/8){scalar_src[7:0]}};
            SEW_16:  rs1_rep = {(VLEN/16){scalar_src[15:0]}};
            SEW_32:  rs1_rep = {(VLEN/32){scalar_src[31:0]}};
            default: rs1_rep = {(VLEN/64){scalar_src}};
        endcase
    end

    assign op_a    = (mode_i == OP_VV) ? vs1_i : rs1_rep;
    assign lane_op = (op_i == VCNT) ? VSEQ : op_i;     // Count reads the compare result

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        simd_lane u_lane (
            .op_i  (lane_op),
            .sew_i (sew_i),
            .a_i   (op_a[g*DATA_SIZE +: DATA_SIZE]),
            .b_i   (vs2_i[g*DATA_SIZE +: DATA_SIZE]),
            .y_o   (raw[g*DATA_SIZE +: DATA_SIZE])
        );
    end

    // Element indexed by rs1, zero when past the last element
    assign ext_shift = vs2_i >> (32'(rs1_i[IDX_W-1:0]) << sh);

    always_comb begin
        ext_val = '0;
        if (rs1_i < (VLEN >> sh)) begin
            ext_val = ext_shift[DATA_SIZE-1:0] & emask;
        end
    end

    always_comb begin
        logic run;
        run = 1'b1;
        cnt = '0;
        for (int e = 0; e < MAX_ELEMS; e++) begin
            if (e < (VLEN >> sh)) begin
                run = run & raw[e << sh];
                if (run) cnt = bus64_t'(e + 1);
            end
        end
    end

    always_comb begin
        case (op_i)
            VMV_X_S: sresult_o = vs2_i[DATA_SIZE-1:0] & emask;
            VEXT:    sresult_o = ext_val;
            VCNT:    sresult_o = cnt;
            default: sresult_o = '0;
        endcase
    end

    // Inactive elements keep old vd
    always_comb begin
        for (int b = 0; b < VLEN; b++) begin
            vresult_o[b] = (!masked_i || vmask_i[b >> sh]) ? raw[b] : old_vd_i[b];
        end
    end

endmodule

/* hw/simd_issue.sv */
`timescale 1ns/10ps

module simd_issue import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              valid_i,
    input  vop_t              op_i,
    input  opmode_t           mode_i,
    input  sew_t              sew_i,
    input  vreg_idx_t         vd_i,
    input  logic              masked_i,
    input  bus64_t            rs1_data_i,
    input  imm_t              imm_i,
    input  logic [VLEN-1:0]   vs1_data_i,
    input  logic [VLEN-1:0]   vs2_data_i,
    input  logic [VLEN-1:0]   old_vd_i,
    input  logic [VLEN/8-1:0] vmask_i,
    output vop_t              op_o,
    output opmode_t           mode_o,
    output sew_t              sew_o,
    output logic              masked_o,
    output bus64_t            rs1_o,
    output imm_t              imm_o,
    output logic [VLEN-1:0]   vs1_o,
    output logic [VLEN-1:0]   vs2_o,
    output logic [VLEN-1:0]   old_vd_o,
    output logic [VLEN/8-1:0] vmask_o,
    input  logic [VLEN-1:0]   vresult_i,
    input  bus64_t            sresult_i,
    vrf_wr_if.requester       wr,
    output logic              scalar_valid_o,
    output bus64_t            scalar_result_o,
    output logic              vec_valid_o,
    output vreg_idx_t         vec_idx_o,
    output logic [VLEN-1:0]   vec_result_o
);

    logic      cap_valid;   // An instruction sits in the ALU this cycle
    vreg_idx_t cap_vd;
    logic      is_scalar;

    assign is_scalar = (op_o == VMV_X_S) || (op_o == VEXT) || (op_o == VCNT);

    // Vector results go straight to the write port
    assign wr.req  = cap_valid && !is_scalar;
    assign wr.idx  = cap_vd;
    assign wr.data = vresult_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= valid_i;
        end
    end

    // Operand capture
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o     <= op_i;
            mode_o   <= mode_i;
            sew_o    <= sew_i;
            masked_o <= masked_i;
            rs1_o    <= rs1_data_i;
            imm_o    <= imm_i;
            cap_vd   <= vd_i;
            vs1_o    <= vs1_data_i;
            vs2_o    <= vs2_data_i;
            old_vd_o <= old_vd_i;
            vmask_o  <= vmask_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            scalar_valid_o  <= 1'b0;
            scalar_result_o <= '0;
            vec_valid_o     <= 1'b0;
            vec_idx_o       <= '0;
            vec_result_o    <= '0;
        end else begin
            scalar_valid_o <= cap_valid && is_scalar;
            vec_valid_o    <= wr.req && wr.gnt;
            if (cap_valid && is_scalar) begin
                scalar_result_o <= sresult_i;
            end
            if (wr.req && wr.gnt) begin     // Mirror of the register write
                vec_idx_o    <= cap_vd;
                vec_result_o <= vresult_i;
            end
        end
    end

endmodule

/* hw/vreg_loader.sv */
`timescale 1ns/10ps

module vreg_loader import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            load_we_i,
    input  vreg_idx_t       load_idx_i,
    input  logic [VLEN-1:0] load_data_i,
    vrf_wr_if.requester     wr,
    output logic            load_busy_o
);

    logic            pend;      // Load waiting for the write port
    vreg_idx_t       pend_idx;
    logic [VLEN-1:0] pend_data;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend <= 1'b0;
        end else if (pend && wr.gnt) begin
            pend <= 1'b0;
        end else if (load_we_i && !pend) begin
            pend <= 1'b1;
        end
    end

    // New strobes are dropped while a load is pending
    always_ff @(posedge clk_i) begin
        if (load_we_i && !pend) begin
            pend_idx  <= load_idx_i;
            pend_data <= load_data_i;
        end
    end

    assign wr.req      = pend;
    assign wr.idx      = pend_idx;
    assign wr.data     = pend_data;
    assign load_busy_o = pend;

endmodule

/* hw/vrf_arbiter.sv */
`timescale 1ns/10ps

module vrf_arbiter import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) (
    vrf_wr_if.arbiter       exec,
    vrf_wr_if.arbiter       load,
    output logic            we_o,
    output vreg_idx_t       widx_o,
    output logic [VLEN-1:0] wdata_o
);

    // Execution never stalls, the loader takes the idle cycles
    assign exec.gnt = exec.req;
    assign load.gnt = load.req && !exec.req;

    assign we_o    = exec.req || load.req;
    assign widx_o  = exec.req ? exec.idx : load.idx;
    assign wdata_o = exec.req ? exec.data : load.data;

endmodule

/* hw/vector_regfile.sv */
`timescale 1ns/10ps

module vector_regfile import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              we_i,
    input  vreg_idx_t         widx_i,
    input  logic [VLEN-1:0]   wdata_i,
    input  vreg_idx_t         ra1_i,
    input  vreg_idx_t         ra2_i,
    input  vreg_idx_t         ra3_i,
    output logic [VLEN-1:0]   rd1_o,
    output logic [VLEN-1:0]   rd2_o,
    output logic [VLEN-1:0]   rd3_o,
    output logic [VLEN/8-1:0] vmask_o,
    input  vreg_idx_t         vread_idx_i,
    output logic [VLEN-1:0]   vread_data_o
);

    logic [VLEN-1:0] regs [NUM_VREGS];
    logic [VLEN-1:0] v0_now;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (we_i) begin
            regs[widx_i] <= wdata_i;
        end
    end

    // Reads of the register being written return the new data
    assign rd1_o   = (we_i && widx_i == ra1_i) ? wdata_i : regs[ra1_i];
    assign rd2_o   = (we_i && widx_i == ra2_i) ? wdata_i : regs[ra2_i];
    assign rd3_o   = (we_i && widx_i == ra3_i) ? wdata_i : regs[ra3_i];
    assign v0_now  = (we_i && widx_i == '0) ? wdata_i : regs[0];
    assign vmask_o = v0_now[VLEN/8-1:0];   // One mask bit per element at SEW 8

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            vread_data_o <= '0;
        end else begin
            vread_data_o <= (we_i && widx_i == vread_idx_i) ? wdata_i : regs[vread_idx_i];
        end
    end

endmodule

/* hw/simd_exec_top.sv */
`timescale 1ns/10ps

module simd_exec_top import simd_pkg::*; #(
    parameter int VLEN = VLEN_DEF
) (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            valid_i,
    input  vop_t            op_i,
    input  opmode_t         mode_i,
    input  sew_t            sew_i,
    input  vreg_idx_t       vd_i,
    input  vreg_idx_t       vs1_i,
    input  vreg_idx_t       vs2_i,
    input  logic            masked_i,
    input  bus64_t          rs1_data_i,
    input  imm_t            imm_i,
    input  logic            load_we_i,
    input  vreg_idx_t       load_idx_i,
    input  logic [VLEN-1:0] load_data_i,
    input  vreg_idx_t       vread_idx_i,
    output logic            scalar_valid_o,
    output bus64_t          scalar_result_o,
    output logic            vec_valid_o,
    output vreg_idx_t       vec_idx_o,
    output logic [VLEN-1:0] vec_result_o,
    output logic [VLEN-1:0] vread_data_o,
    output logic            load_busy_o
);

    logic [VLEN-1:0]   vs1_data, vs2_data, old_vd;      // Register file reads
    logic [VLEN/8-1:0] vmask;
    vop_t              alu_op;
    opmode_t           alu_mode;
    sew_t              alu_sew;
    logic              alu_masked;
    bus64_t            alu_rs1;
    imm_t              alu_imm;
    logic [VLEN-1:0]   alu_vs1, alu_vs2, alu_old_vd;
    logic [VLEN/8-1:0] alu_vmask;
    logic [VLEN-1:0]   vresult;
    bus64_t            sresult;
    logic              we;
    vreg_idx_t         widx;
    logic [VLEN-1:0]   wdata;

    vrf_wr_if #(.VLEN(VLEN)) exec_wr ();
    vrf_wr_if #(.VLEN(VLEN)) load_wr ();

    simd_issue #(.VLEN(VLEN)) u_issue (
        .clk_i, .reset_i, .valid_i, .op_i, .mode_i, .sew_i, .vd_i, .masked_i,
        .rs1_data_i, .imm_i,
        .vs1_data_i (vs1_data),    .vs2_data_i (vs2_data),
        .old_vd_i   (old_vd),      .vmask_i    (vmask),
        .op_o       (alu_op),      .mode_o     (alu_mode),
        .sew_o      (alu_sew),     .masked_o   (alu_masked),
        .rs1_o      (alu_rs1),     .imm_o      (alu_imm),
        .vs1_o      (alu_vs1),     .vs2_o      (alu_vs2),
        .old_vd_o   (alu_old_vd),  .vmask_o    (alu_vmask),
        .vresult_i  (vresult),     .sresult_i  (sresult),
        .wr         (exec_wr.requester),
        .scalar_valid_o, .scalar_result_o, .vec_valid_o, .vec_idx_o, .vec_result_o
    );

    simd_alu #(.VLEN(VLEN)) u_alu (
        .op_i     (alu_op),     .mode_i  (alu_mode),  .sew_i    (alu_sew),
        .masked_i (alu_masked), .rs1_i   (alu_rs1),   .imm_i    (alu_imm),
        .vs1_i    (alu_vs1),    .vs2_i   (alu_vs2),   .old_vd_i (alu_old_vd),
        .vmask_i  (alu_vmask),  .vresult_o (vresult), .sresult_o (sresult)
    );

    vreg_loader #(.VLEN(VLEN)) u_loader (
        .clk_i, .reset_i, .load_we_i, .load_idx_i, .load_data_i,
        .wr (load_wr.requester),
        .load_busy_o
    );

    vrf_arbiter #(.VLEN(VLEN)) u_arbiter (
        .exec    (exec_wr.arbiter),
        .load    (load_wr.arbiter),
        .we_o    (we),
        .widx_o  (widx),
        .wdata_o (wdata)
    );

    // vd is read as the old value for masked-off elements
    vector_regfile #(.VLEN(VLEN)) u_regfile (
        .clk_i, .reset_i,
        .we_i    (we),       .widx_i  (widx),     .wdata_i (wdata),
        .ra1_i   (vs1_i),    .ra2_i   (vs2_i),    .ra3_i   (vd_i),
        .rd1_o   (vs1_data), .rd2_o   (vs2_data), .rd3_o   (old_vd),
        .vmask_o (vmask),
        .vread_idx_i, .vread_data_o
    );

endmodule

/* testbench/simd_exec_chk.sv */
`timescale 1ns/10ps

module simd_exec_chk (
    input logic clk_i,
    input logic reset_i,
    input logic valid_i,
    input logic scalar_valid_i,
    input logic vec_valid_i,
    input logic load_busy_i
);

    int unsigned fail_count = 0;    // Failed assertions so far

    // A result is either scalar or vector but never both
    a_one_result: assert property (@(posedge clk_i) disable iff (reset_i)
        !(scalar_valid_i && vec_valid_i))
        else begin
            $error("scalar and vector results valid in the same cycle");
            fail_count++;
        end

    // Strobe sampled at edge N gives a result sampled at edge N+2
    a_result_follows: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_i |-> ##2 (scalar_valid_i || vec_valid_i))
        else begin
            $error("no result one cycle after an instruction strobe");
            fail_count++;
        end

    a_no_stray_result: assert property (@(posedge clk_i) disable iff (reset_i)
        (scalar_valid_i || vec_valid_i) |-> $past(valid_i, 2))
        else begin
            $error("result valid without a strobe one cycle before");
            fail_count++;
        end

    a_load_ends: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(load_busy_i) |-> ##[1:64] !load_busy_i)
        else begin
            $error("load_busy_o stayed high too long");
            fail_count++;
        end

    // Outputs settle after the first reset edge
    a_quiet_in_reset: assert property (@(posedge clk_i)
        (reset_i && $past(reset_i)) |-> (!scalar_valid_i && !vec_valid_i && !load_busy_i))
        else begin
            $error("valid or busy output high during reset");
            fail_count++;
        end

endmodule

bind simd_exec_top simd_exec_chk u_chk (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .valid_i        (valid_i),
    .scalar_valid_i (scalar_valid_o),
    .vec_valid_i    (vec_valid_o),
    .load_busy_i    (load_busy_o)
);

/* testbench/simd_exec_tb.sv */
`timescale 1ns/10ps

module simd_exec_tb import simd_pkg::*; ();

    localparam int VLEN           = VLEN_DEF;
    localparam int LOAD_TIMEOUT   = 40;     // Cycles
    localparam int RESULT_TIMEOUT = 10;

    typedef logic [VLEN-1:0] vreg_t;

    typedef struct packed {
        logic      is_scalar;
        vreg_idx_t idx;
        bus64_t    sc;
        vreg_t     vec;
        int        due;
    } expect_t;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      valid_i;
    vop_t      op_i;
    opmode_t   mode_i;
    sew_t      sew_i;
    vreg_idx_t vd_i, vs1_i, vs2_i;
    logic      masked_i;
    bus64_t    rs1_data_i;
    imm_t      imm_i;
    logic      load_we_i;
    vreg_idx_t load_idx_i;
    vreg_t     load_data_i;
    vreg_idx_t vread_idx_i;
    logic      scalar_valid_o;
    bus64_t    scalar_result_o;
    logic      vec_valid_o;
    vreg_idx_t vec_idx_o;
    vreg_t     vec_result_o;
    vreg_t     vread_data_o;
    logic      load_busy_o;

    vreg_t       model_regs [NUM_VREGS];
    expect_t     exp_q [$];                 // Instructions in flight
    logic [31:0] lfsr_state = 32'hc4012c70;
    int          cycle_cnt = 0;             // Rising edges so far

    simd_exec_top #(.VLEN(VLEN)) dut (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt++;

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_bus64(input string name, input bus64_t got, input bus64_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vreg(input string name, input vreg_t got, input vreg_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input vreg_idx_t got, input vreg_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic bus64_t rand_bits(input int n);
        bus64_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int rand_range(input int n);
        return int'(rand_bits(8)) % n;
    endfunction

    function automatic vreg_t rand_vreg();
        vreg_t v;
        for (int g = 0; g < VLEN / 64; g++) begin
            v[g*64 +: 64] = rand_bits(64);
        end
        return v;
    endfunction

    function automatic int elem_w(input sew_t s);
        return 8 << int'(s);
    endfunction

    function automatic int num_elems(input sew_t s);
        return VLEN / elem_w(s);
    endfunction

    function automatic bus64_t elem_mask(input sew_t s);
        return (elem_w(s) == 64) ? '1 : (64'd1 << elem_w(s)) - 64'd1;
    endfunction

    function automatic bus64_t get_elem(input vreg_t v, input int e, input sew_t s);
        return bus64_t'(v >> (e * elem_w(s))) & elem_mask(s);
    endfunction

    function automatic vreg_t put_elem(input vreg_t v, input int e, input sew_t s,
                                       input bus64_t val);
        vreg_t m;
        m = vreg_t'(elem_mask(s)) << (e * elem_w(s));
        return (v & ~m) | ((vreg_t'(val & elem_mask(s)) << (e * elem_w(s))));
    endfunction

    // Immediate is sign-extended to 64 bits before replication
    function automatic bus64_t scalar_of(input opmode_t mode, input bus64_t rs1, input imm_t imm);
        return (mode == OP_VI) ? {{59{imm[4]}}, imm} : rs1;
    endfunction

    function automatic vreg_t model_vec(input vop_t op, input opmode_t mode, input sew_t sew,
                                        input logic masked, input bus64_t rs1, input imm_t imm,
                                        input vreg_t va, input vreg_t vb, input vreg_t vold,
                                        input vreg_t v0);
        vreg_t  res;
        bus64_t a, b, r;
        res = '0;
        for (int e = 0; e < num_elems(sew); e++) begin
            a = (mode == OP_VV) ? get_elem(va, e, sew) : scalar_of(mode, rs1, imm) & elem_mask(sew);
            b = get_elem(vb, e, sew);
            case (op)
                VADD:    r = b + a;
                VSUB:    r = b - a;
                VAND:    r = b & a;
                VOR:     r = b | a;
                VXOR:    r = b ^ a;
                default: r = (a == b) ? '1 : '0;
            endcase
            if (masked && !v0[e]) r = get_elem(vold, e, sew);     // Inactive keeps old vd
            res = put_elem(res, e, sew, r);
        end
        return res;
    endfunction

    function automatic bus64_t model_scalar(input vop_t op, input opmode_t mode, input sew_t sew,
                                            input bus64_t rs1, input imm_t imm,
                                            input vreg_t va, input vreg_t vb);
        bus64_t a, r;
        logic   run;
        r   = '0;
        run = 1'b1;
        case (op)
            VMV_X_S: r = get_elem(vb, 0, sew);
            VEXT: begin
                if (rs1 < 64'(num_elems(sew))) r = get_elem(vb, int'(rs1), sew);
            end
            default: begin
                for (int e = 0; e < num_elems(sew); e++) begin
                    a = (mode == OP_VV) ? get_elem(va, e, sew)
                                        : scalar_of(mode, rs1, imm) & elem_mask(sew);
                    if (a != get_elem(vb, e, sew)) run = 1'b0;
                    if (run) r = 64'(e + 1);
                end
            end
        endcase
        return r;
    endfunction

    // One strobe per call with the model updated in program order
    task automatic drive_op(input vop_t op, input opmode_t mode, input sew_t sew,
                            input vreg_idx_t vd, input vreg_idx_t vs1, input vreg_idx_t vs2,
                            input logic masked, input bus64_t rs1, input imm_t imm);
        expect_t x;
        @(negedge clk_i);
        valid_i    = 1'b1;
        op_i       = op;
        mode_i     = mode;
        sew_i      = sew;
        vd_i       = vd;
        vs1_i      = vs1;
        vs2_i      = vs2;
        masked_i   = masked;
        rs1_data_i = rs1;
        imm_i      = imm;
        x.is_scalar = (op == VMV_X_S) || (op == VEXT) || (op == VCNT);
        x.idx       = vd;
        x.sc        = '0;
        x.vec       = '0;
        x.due       = cycle_cnt + 2;    // Capture edge, then the result edge
        if (x.is_scalar) begin
            x.sc = model_scalar(op, mode, sew, rs1, imm, model_regs[vs1], model_regs[vs2]);
        end else begin
            x.vec = model_vec(op, mode, sew, masked, rs1, imm, model_regs[vs1],
                              model_regs[vs2], model_regs[vd], model_regs[0]);
            model_regs[vd] = x.vec;
        end
        exp_q.push_back(x);
    endtask

    task automatic stop_ops();
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic wait_results();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < RESULT_TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) report_error("timeout waiting for an instruction result");
        @(negedge clk_i);
    endtask

    task automatic wait_load_done();
        int n;
        n = 0;
        while (load_busy_o && n < LOAD_TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (load_busy_o) report_error("timeout waiting for load_busy_o to fall");
    endtask

    task automatic readback_all();
        for (int r = 0; r < NUM_VREGS; r++) begin
            @(negedge clk_i);
            vread_idx_i = vreg_idx_t'(r);
            @(negedge clk_i);
            check_vreg($sformatf("vread_data_o[v%0d]", r), vread_data_o, model_regs[r]);
        end
    endtask

    task automatic load_reg(input vreg_idx_t idx, input vreg_t data);
        @(negedge clk_i);
        load_we_i   = 1'b1;
        load_idx_i  = idx;
        load_data_i = data;
        @(negedge clk_i);
        load_we_i = 1'b0;
        if (!load_busy_o) report_error("load_busy_o did not rise after a load strobe");
        wait_load_done();
        model_regs[idx] = data;
        readback_all();
    endtask

    // Results are compared in issue order
    always @(negedge clk_i) begin
        expect_t x;
        if (dut.u_chk.fail_count != 0) begin
            report_error("an assertion in the bound checker failed");
        end
        if (!reset_i && (scalar_valid_o || vec_valid_o)) begin
            if (exp_q.size() == 0) begin
                report_error("result valid with no instruction in flight");
            end else begin
                x = exp_q.pop_front();
                if (cycle_cnt != x.due) begin
                    report_error("result valid in the wrong cycle after its strobe");
                end
                if (x.is_scalar !== scalar_valid_o || scalar_valid_o === vec_valid_o) begin
                    report_error("result kind does not match the instruction");
                end
                if (x.is_scalar) begin
                    check_bus64("scalar_result_o", scalar_result_o, x.sc);
                end else begin
                    check_idx("vec_idx_o", vec_idx_o, x.idx);
                    check_vreg("vec_result_o", vec_result_o, x.vec);
                end
            end
        end
    end

    initial begin
        sew_t      sew;
        vreg_idx_t vd, prev_vd;
        bus64_t    xv, m;
        vreg_t     va, vb, ld_data;
        int        k;
        reset_i     = 1'b1;
        valid_i     = 1'b0;
        op_i        = VADD;
        mode_i      = OP_VV;
        sew_i       = SEW_8;
        vd_i        = '0;
        vs1_i       = '0;
        vs2_i       = '0;
        masked_i    = 1'b0;
        rs1_data_i  = '0;
        imm_i       = '0;
        load_we_i   = 1'b0;
        load_idx_i  = '0;
        load_data_i = '0;
        vread_idx_i = '0;
        for (int r = 0; r < NUM_VREGS; r++) model_regs[r] = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        readback_all();

        for (int r = 0; r < NUM_VREGS; r++) load_reg(vreg_idx_t'(r), rand_vreg());

        // Random vector ops with random idle gaps
        for (int i = 0; i < 240; i++) begin
            drive_op(vop_t'(rand_range(6)), opmode_t'(rand_range(3)), sew_t'(rand_bits(2)),
                     vreg_idx_t'(rand_bits(3)), vreg_idx_t'(rand_bits(3)),
                     vreg_idx_t'(rand_bits(3)), rand_bits(1), rand_bits(64), imm_t'(rand_bits(5)));
            if (rand_bits(1) == 1) stop_ops();
            if (i % 40 == 39) begin
                stop_ops();
                wait_results();
                load_reg(vreg_idx_t'(rand_bits(3)), rand_vreg());
            end
        end
        stop_ops();
        wait_results();
        readback_all();

        // Element 0 move and indexed extract with indices past the end too
        for (int i = 0; i < 60; i++) begin
            m = (rand_bits(1) == 1) ? rand_bits(64) : rand_bits(5);
            drive_op((rand_bits(1) == 1) ? VEXT : VMV_X_S, opmode_t'(rand_range(3)),
                     sew_t'(rand_bits(2)), vreg_idx_t'(rand_bits(3)), vreg_idx_t'(rand_bits(3)),
                     vreg_idx_t'(rand_bits(3)), rand_bits(1), m, imm_t'(rand_bits(5)));
        end
        stop_ops();
        wait_results();

        // Runs of equal elements of random length in v2 with the run value in v3
        for (int t = 0; t < 16; t++) begin
            sew = sew_t'(rand_bits(2));
            m   = elem_mask(sew);
            xv  = rand_bits(64) & m;
            k   = rand_range(num_elems(sew) + 1);
            vb  = rand_vreg();
            va  = '0;
            for (int e = 0; e < num_elems(sew); e++) begin
                va = put_elem(va, e, sew, xv);
                if (e < k) vb = put_elem(vb, e, sew, xv);
                if (e == k) vb = put_elem(vb, e, sew, xv + 64'd1);   // Run breaks here
            end
            load_reg(3'd2, vb);
            load_reg(3'd3, va);
            drive_op(VCNT, OP_VV, sew, 3'd0, 3'd3, 3'd2, rand_bits(1), rand_bits(64), 5'd0);
            drive_op(VCNT, OP_VX, sew, 3'd0, 3'd5, 3'd2, 1'b0, (rand_bits(64) & ~m) | xv, 5'd0);
            drive_op(VCNT, OP_VI, sew, 3'd0, 3'd5, 3'd2, 1'b0, '0, imm_t'(rand_bits(5)));
            stop_ops();
            wait_results();
        end

        // Dependent back-to-back ops while a load to v7 waits for the write port
        ld_data = rand_vreg();
        prev_vd = 3'd1;
        for (int i = 0; i < 10; i++) begin
            vd = vreg_idx_t'(1 + rand_range(6));
            drive_op(vop_t'(rand_range(6)), opmode_t'(rand_range(3)), sew_t'(rand_bits(2)), vd,
                     vreg_idx_t'(rand_bits(3)), prev_vd, rand_bits(1), rand_bits(64),
                     imm_t'(rand_bits(5)));
            prev_vd     = vd;
            load_we_i   = (i == 0) || (i == 4);    // Second strobe lands while busy
            load_idx_i  = 3'd7;
            load_data_i = (i == 0) ? ld_data : rand_vreg();
        end
        stop_ops();
        load_we_i = 1'b0;
        if (!load_busy_o) report_error("load finished before execution stopped");
        wait_load_done();
        model_regs[7] = ld_data;
        wait_results();
        readback_all();

        if (dut.u_chk.fail_count != 0) begin
            report_error("an assertion in the bound checker failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* vlog.f */
hw/simd_pkg.sv
hw/vrf_wr_if.sv
hw/simd_lane.sv
hw/simd_alu.sv
hw/simd_issue.sv
hw/vreg_loader.sv
hw/vrf_arbiter.sv
hw/vector_regfile.sv
hw/simd_exec_top.sv
testbench/simd_exec_chk.sv
testbench/simd_exec_tb.sv
